// File: sources.f
+incdir+tests
design/dnc_write_types_pkg.sv
design/dnc_write_ctrl_pkg.sv
design/hidden_state_buffer.sv
design/row_dot_product.sv
design/write_interface_ctrl.sv
design/dnc_write_interface_vector.sv
tests/write_interface_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the write-interface testbench with Verilator, runs it and checks the log.
# Exit status is 0 on pass, 1 on build error, simulator error or failed checks.

ROOT_DIR=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT_DIR" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=write_interface_sim
LOG_FILE=sim.log
FAIL_MSG="Checks failed"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module write_interface_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "$FAIL_MSG" "$LOG_FILE"; then
  echo "Result: FAIL"
  exit 1
fi

echo "Result: PASS"
exit 0

// File: tests/write_interface_model.svh
// Reference model built from the Q8.8 rules, independent of the RTL datapath
// Needs both design packages imported by the including module
`ifndef WRITE_INTERFACE_MODEL_SVH
`define WRITE_INTERFACE_MODEL_SVH

////////////////////////////////////////////////////////////
// Weight stream layout
////////////////////////////////////////////////////////////

// Rows of k, e and v, then beta, ga and gw
localparam int NUM_ROWS    = 3 * SIZE_W + 3;
localparam int NUM_WEIGHTS = NUM_ROWS * SIZE_L;

// Output fed by a row of the stream
function automatic result_kind_e kind_of_row(input int row);
  if (row < SIZE_W) begin
    return KIND_K;
  end else if (row < 2 * SIZE_W) begin
    return KIND_E;
  end else if (row < 3 * SIZE_W) begin
    return KIND_V;
  end else if (row == 3 * SIZE_W) begin
    return KIND_BETA;
  end else if (row == 3 * SIZE_W + 1) begin
    return KIND_GA;
  end
  return KIND_GW;
endfunction

// Printable name of a result, vector element index included
function automatic string row_label(input int row);
  int elem;
  elem = row % SIZE_W;
  case (kind_of_row(row))
    KIND_K:    return $sformatf("k[%0d]", elem);
    KIND_E:    return $sformatf("e[%0d]", elem);
    KIND_V:    return $sformatf("v[%0d]", elem);
    KIND_BETA: return "beta";
    KIND_GA:   return "ga";
    default:   return "gw";
  endcase
endfunction

////////////////////////////////////////////////////////////
// Arithmetic
////////////////////////////////////////////////////////////

// Q16.16 sum back to Q8.8, clamped to the signed 16-bit range
function automatic data_t saturate_q88(input longint sum);
  longint scaled;
  scaled = sum >>> 8;
  if (scaled > 32767) begin
    return 16'sh7FFF;
  end else if (scaled < -32768) begin
    return 16'sh8000;
  end
  return data_t'(scaled);
endfunction

// One weight row times h, exact sum before rounding down
function automatic data_t row_dot(input data_t w[NUM_WEIGHTS], input data_t h[SIZE_L],
                                  input int row);
  longint sum;
  int c;
  sum = 0;
  for (c = 0; c < SIZE_L; c++) begin
    sum += longint'(w[row * SIZE_L + c]) * longint'(h[c]);
  end
  return saturate_q88(sum);
endfunction

`endif

// File: tests/write_interface_tb.sv
// Random and directed jobs, every output pulse checked against the Q8.8 model
// Inputs change on the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ns

module write_interface_tb;

  import dnc_write_types_pkg::*;
  import dnc_write_ctrl_pkg::*;

  `include "write_interface_model.svh"

  localparam int SEED_INIT      = 96;
  localparam int RANDOM_RUNS    = 4;
  // Random runs, two saturation, one with strays, two back-to-back
  localparam int TOTAL_JOBS     = RANDOM_RUNS + 5;
  // Strobes plus start and drain, gaps covered by the factor two
  localparam int JOB_CYCLES     = SIZE_L + NUM_WEIGHTS + 8;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_JOBS * JOB_CYCLES + 200;

  logic  CLK;
  logic  RST;
  logic  start;
  logic  ready;
  data_t h_in;
  logic  h_in_enable;
  data_t w_in;
  logic  w_in_enable;
  data_t k_out;
  data_t e_out;
  data_t v_out;
  data_t beta_out;
  data_t ga_out;
  data_t gw_out;
  logic  k_out_enable;
  logic  e_out_enable;
  logic  v_out_enable;
  logic  beta_out_enable;
  logic  ga_out_enable;
  logic  gw_out_enable;

  integer seed;
  int     errors;
  int     checks;
  int     err_mark;
  int     ready_count;
  int     ready_mark;
  int     cycle_count;
  bit     gw_prev;
  string  test_name;

  // Stimulus of the current job
  data_t h_vec [SIZE_L];
  data_t w_vec [NUM_WEIGHTS];

  // Expected results in arrival order
  result_kind_e exp_kind [$];
  data_t        exp_val  [$];
  int           exp_row  [$];

  dnc_write_interface_vector dut_i (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .ready           (ready),
    .h_in            (h_in),
    .h_in_enable     (h_in_enable),
    .w_in            (w_in),
    .w_in_enable     (w_in_enable),
    .k_out           (k_out),
    .k_out_enable    (k_out_enable),
    .e_out           (e_out),
    .e_out_enable    (e_out_enable),
    .v_out           (v_out),
    .v_out_enable    (v_out_enable),
    .beta_out        (beta_out),
    .beta_out_enable (beta_out_enable),
    .ga_out          (ga_out),
    .ga_out_enable   (ga_out_enable),
    .gw_out          (gw_out),
    .gw_out_enable   (gw_out_enable)
  );

  always #4 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input data_t expected, input data_t actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  // Pops the oldest expectation and matches output and value
  task automatic check_result(input result_kind_e kind, input data_t actual);
    result_kind_e want_kind;
    data_t        want_val;
    int           row;
    checks++;
    assert (exp_val.size() > 0) else begin
      $display("%s: %s pulse with no result pending", test_name, kind.name());
      errors++;
    end
    if (exp_val.size() > 0) begin
      want_kind = exp_kind.pop_front();
      want_val  = exp_val.pop_front();
      row       = exp_row.pop_front();
      checks++;
      assert (want_kind == kind) else begin
        $display("%s: %s arrived on the %s output", test_name, row_label(row), kind.name());
        errors++;
      end
      check_value(row_label(row), want_val, actual);
    end
  endtask

  // Output monitor, one pass per falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (k_out_enable)    check_result(KIND_K, k_out);
      if (e_out_enable)    check_result(KIND_E, e_out);
      if (v_out_enable)    check_result(KIND_V, v_out);
      if (beta_out_enable) check_result(KIND_BETA, beta_out);
      if (ga_out_enable)   check_result(KIND_GA, ga_out);
      if (gw_out_enable)   check_result(KIND_GW, gw_out);
      if (ready) begin
        ready_count++;
        checks++;
        assert (gw_prev) else begin
          $display("%s: ready pulsed without a gw result the cycle before", test_name);
          errors++;
        end
      end
      gw_prev = gw_out_enable;
    end
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles in %s", cycle_count, test_name);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Next rising edge, strobes default to low
  task automatic tick();
    @(posedge CLK);
    start       <= 1'b0;
    h_in_enable <= 1'b0;
    w_in_enable <= 1'b0;
  endtask

  // About one strobe in four gets an idle cycle ahead of it
  task automatic maybe_gap(input bit gaps);
    if (gaps && (($random(seed) & 3) == 0)) begin
      tick();
    end
  endtask

  // Up to about 4.0 in magnitude, rows stay clear of the clamp
  function automatic data_t small_value();
    return data_t'($random(seed) % 1024);
  endfunction

  task automatic fill_random();
    int i;
    for (i = 0; i < SIZE_L; i++) begin
      h_vec[i] = small_value();
    end
    for (i = 0; i < NUM_WEIGHTS; i++) begin
      w_vec[i] = small_value();
    end
  endtask

  // Every h and weight at one bound, odd rows flipped to the minimum on request
  task automatic fill_extreme(input data_t bound, input bit alternate);
    int i;
    for (i = 0; i < SIZE_L; i++) begin
      h_vec[i] = bound;
    end
    for (i = 0; i < NUM_WEIGHTS; i++) begin
      w_vec[i] = (alternate && ((i / SIZE_L) % 2 == 1)) ? 16'sh8000 : bound;
    end
  endtask

  task automatic push_expected();
    int r;
    for (r = 0; r < NUM_ROWS; r++) begin
      exp_kind.push_back(kind_of_row(r));
      exp_val.push_back(row_dot(w_vec, h_vec, r));
      exp_row.push_back(r);
    end
  endtask

  // One job, returns on the falling edge where ready is seen
  task automatic run_job(input bit gaps, input bit strays);
    int j;
    push_expected();
    tick();
    start <= 1'b1;
    for (j = 0; j < SIZE_L; j++) begin
      maybe_gap(gaps);
      tick();
      h_in        <= h_vec[j];
      h_in_enable <= 1'b1;
    end
    for (j = 0; j < NUM_WEIGHTS; j++) begin
      maybe_gap(gaps);
      tick();
      w_in        <= w_vec[j];
      w_in_enable <= 1'b1;
      // Mid-stream start and h strobe, both outside their phase
      if (strays && j == NUM_WEIGHTS / 2) begin
        start       <= 1'b1;
        h_in        <= data_t'($random(seed));
        h_in_enable <= 1'b1;
      end
    end
    tick();
    do @(negedge CLK); while (!ready);
  endtask

  task automatic begin_test(input string name);
    test_name  = name;
    err_mark   = errors;
    ready_mark = ready_count;
  endtask

  // Idle cycles catch late or stray pulses
  task automatic end_test(input int jobs);
    repeat (4) tick();
    checks++;
    assert (exp_val.size() == 0) else begin
      $display("%s: %0d expected results never arrived", test_name, exp_val.size());
      errors++;
    end
    checks++;
    assert (ready_count - ready_mark == jobs) else begin
      $display("%s: ready pulsed %0d times for %0d jobs", test_name,
               ready_count - ready_mark, jobs);
      errors++;
    end
    $display("test %s: %s, %0d errors", test_name, (errors == err_mark) ? "pass" : "fail",
             errors - err_mark);
    exp_kind.delete();
    exp_val.delete();
    exp_row.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed        = SEED_INIT;
    CLK         = 1'b0;
    RST         = 1'b1;
    start       = 1'b0;
    h_in        = '0;
    h_in_enable = 1'b0;
    w_in        = '0;
    w_in_enable = 1'b0;
    errors      = 0;
    checks      = 0;
    ready_count = 0;
    cycle_count = 0;
    gw_prev     = 1'b0;
    test_name   = "reset_idle";
    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    // Cleared outputs, and strobes without start do nothing
    begin_test("reset_idle");
    @(negedge CLK);
    check_value("ready and enables", '0, data_t'({ready, k_out_enable, e_out_enable,
                v_out_enable, beta_out_enable, ga_out_enable, gw_out_enable}));
    check_value("k_out", '0, k_out);
    check_value("e_out", '0, e_out);
    check_value("v_out", '0, v_out);
    check_value("beta_out", '0, beta_out);
    check_value("ga_out", '0, ga_out);
    check_value("gw_out", '0, gw_out);
    tick();
    h_in        <= 16'sh0100;
    h_in_enable <= 1'b1;
    w_in        <= 16'sh0100;
    w_in_enable <= 1'b1;
    end_test(0);

    // Vector elements in index order, then the three scalars
    begin_test("random_small");
    repeat (RANDOM_RUNS) begin
      fill_random();
      run_job(1'b0, 1'b0);
    end
    end_test(RANDOM_RUNS);

    begin_test("saturation");
    fill_extreme(16'sh7FFF, 1'b1);
    run_job(1'b0, 1'b0);
    fill_extreme(16'sh8000, 1'b0);
    run_job(1'b0, 1'b0);
    end_test(2);

    begin_test("gaps_and_strays");
    fill_random();
    run_job(1'b1, 1'b1);
    end_test(1);

    // Second start lands in the cycle after ready
    begin_test("back_to_back");
    fill_random();
    run_job(1'b1, 1'b0);
    fill_random();
    run_job(1'b0, 1'b0);
    end_test(2);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: design/dnc_write_interface_vector.sv
// Write-interface stage: k, e, v and beta, ga, gw from hidden state h
// No nonlinearities applied; outputs are raw saturated Q8.8 dot products
`timescale 1ns/1ns

module dnc_write_interface_vector (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       start,
  output logic                       ready,
  input  dnc_write_types_pkg::data_t h_in,
  input  logic                       h_in_enable,
  input  dnc_write_types_pkg::data_t w_in,
  input  logic                       w_in_enable,
  output dnc_write_types_pkg::data_t k_out,
  output logic                       k_out_enable,
  output dnc_write_types_pkg::data_t e_out,
  output logic                       e_out_enable,
  output dnc_write_types_pkg::data_t v_out,
  output logic                       v_out_enable,
  output dnc_write_types_pkg::data_t beta_out,
  output logic                       beta_out_enable,
  output dnc_write_types_pkg::data_t ga_out,
  output logic                       ga_out_enable,
  output dnc_write_types_pkg::data_t gw_out,
  output logic                       gw_out_enable
);

  import dnc_write_types_pkg::*;

  // Buffer side
  logic             h_write;
  logic [IDX_W-1:0] h_index;
  data_t            h_elem;

  // MAC side
  logic  mac_enable;
  logic  row_first;
  logic  row_last;
  data_t row_result;
  logic  row_done;

  hidden_state_buffer buffer_i (
    .CLK     (CLK),
    .RST     (RST),
    .h_write (h_write),
    .h_index (h_index),
    .h_in    (h_in),
    .h_elem  (h_elem)
  );

  // Weight bus feeds the MAC directly
  row_dot_product mac_i (
    .CLK        (CLK),
    .RST        (RST),
    .mac_enable (mac_enable),
    .row_first  (row_first),
    .row_last   (row_last),
    .w_elem     (w_in),
    .h_elem     (h_elem),
    .row_result (row_result),
    .row_done   (row_done)
  );

  write_interface_ctrl ctrl_i (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .h_in_enable     (h_in_enable),
    .w_in_enable     (w_in_enable),
    .row_result      (row_result),
    .row_done        (row_done),
    .h_write         (h_write),
    .h_index         (h_index),
    .mac_enable      (mac_enable),
    .row_first       (row_first),
    .row_last        (row_last),
    .ready           (ready),
    .k_out           (k_out),
    .e_out           (e_out),
    .v_out           (v_out),
    .beta_out        (beta_out),
    .ga_out          (ga_out),
    .gw_out          (gw_out),
    .k_out_enable    (k_out_enable),
    .e_out_enable    (e_out_enable),
    .v_out_enable    (v_out_enable),
    .beta_out_enable (beta_out_enable),
    .ga_out_enable   (ga_out_enable),
    .gw_out_enable   (gw_out_enable)
  );

endmodule

// File: design/write_interface_ctrl.sv
// Sequences h load and the weight rows, steers finished rows to outputs
// Expects exactly SIZE_L h strobes, then all weights in k, e, v, beta, ga, gw order
// Output pulses have no back-pressure
`timescale 1ns/1ns

module write_interface_ctrl (
  input  logic                                  CLK,
  input  logic                                  RST,
  input  logic                                  start,
  input  logic                                  h_in_enable,
  input  logic                                  w_in_enable,
  input  dnc_write_types_pkg::data_t            row_result,
  input  logic                                  row_done,
  output logic                                  h_write,
  output logic [dnc_write_types_pkg::IDX_W-1:0] h_index,
  output logic                                  mac_enable,
  output logic                                  row_first,
  output logic                                  row_last,
  output logic                                  ready,
  output dnc_write_types_pkg::data_t            k_out,
  output dnc_write_types_pkg::data_t            e_out,
  output dnc_write_types_pkg::data_t            v_out,
  output dnc_write_types_pkg::data_t            beta_out,
  output dnc_write_types_pkg::data_t            ga_out,
  output dnc_write_types_pkg::data_t            gw_out,
  output logic                                  k_out_enable,
  output logic                                  e_out_enable,
  output logic                                  v_out_enable,
  output logic                                  beta_out_enable,
  output logic                                  ga_out_enable,
  output logic                                  gw_out_enable
);

  import dnc_write_types_pkg::*;
  import dnc_write_ctrl_pkg::*;

  write_phase_e         phase;
  logic [IDX_W-1:0]     col;
  logic [ROW_IDX_W-1:0] row;
  logic                 row_phase;
  logic                 vec_phase;
  logic                 h_accept;
  logic                 w_accept;
  logic                 col_last;
  logic                 phase_end;
  result_kind_e         cur_kind;
  // Kinds of rows still inside the dot-product unit, head at 0
  result_kind_e         kind_q [2];
  logic [1:0]           kind_cnt;

  // Phase order of the weight stream
  function automatic write_phase_e next_row_phase(write_phase_e p);
    case (p)
      ROWS_K:   return ROWS_E;
      ROWS_E:   return ROWS_V;
      ROWS_V:   return ROW_BETA;
      ROW_BETA: return ROW_GA;
      ROW_GA:   return ROW_GW;
      default:  return FINISH;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Phase decode and strobes
  ////////////////////////////////////////////////////////////

  always_comb begin
    row_phase = 1'b1;
    vec_phase = 1'b0;
    cur_kind  = KIND_K;
    case (phase)
      ROWS_K: begin
        vec_phase = 1'b1;
      end
      ROWS_E: begin
        vec_phase = 1'b1;
        cur_kind  = KIND_E;
      end
      ROWS_V: begin
        vec_phase = 1'b1;
        cur_kind  = KIND_V;
      end
      ROW_BETA: cur_kind = KIND_BETA;
      ROW_GA:   cur_kind = KIND_GA;
      ROW_GW:   cur_kind = KIND_GW;
      default:  row_phase = 1'b0;
    endcase
  end

  // Strobes outside their phase fall through here
  assign h_accept  = (phase == LOAD_H) && h_in_enable;
  assign w_accept  = row_phase && w_in_enable;
  assign col_last  = (col == IDX_W'(SIZE_L - 1));
  // Scalar phases are a single row
  assign phase_end = w_accept && col_last && (!vec_phase || (row == ROW_IDX_W'(SIZE_W - 1)));

  assign h_write    = h_accept;
  assign h_index    = col;
  assign mac_enable = w_accept;
  assign row_first  = w_accept && (col == '0);
  assign row_last   = w_accept && col_last;

  ////////////////////////////////////////////////////////////
  // Phase FSM and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase <= IDLE;
      col   <= '0;
      row   <= '0;
      ready <= 1'b0;
    end else begin
      // Pulse once the gw result is out
      ready <= (phase == FINISH) && gw_out_enable;
      case (phase)
        IDLE: begin
          if (start) begin
            phase <= LOAD_H;
            col   <= '0;
            row   <= '0;
          end
        end
        LOAD_H: begin
          if (h_accept) begin
            if (col_last) begin
              col   <= '0;
              phase <= ROWS_K;
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        ROWS_K, ROWS_E, ROWS_V, ROW_BETA, ROW_GA, ROW_GW: begin
          if (w_accept) begin
            if (col_last) begin
              col <= '0;
              if (phase_end) begin
                row   <= '0;
                phase <= next_row_phase(phase);
              end else begin
                row <= row + 1'b1;
              end
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        // Wait for the last row to leave the MAC
        FINISH: begin
          if (gw_out_enable) begin
            phase <= IDLE;
          end
        end
        default: phase <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Result kind queue
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      kind_cnt  <= '0;
      kind_q[0] <= KIND_K;
      kind_q[1] <= KIND_K;
    end else begin
      case ({row_last, row_done})
        2'b10: begin
          kind_q[kind_cnt[0]] <= cur_kind;
          kind_cnt            <= kind_cnt + 1'b1;
        end
        2'b01: begin
          kind_q[0] <= kind_q[1];
          kind_cnt  <= kind_cnt - 1'b1;
        end
        // Pop and push together, depth unchanged
        2'b11: begin
          if (kind_cnt == 2'd2) begin
            kind_q[0] <= kind_q[1];
            kind_q[1] <= cur_kind;
          end else begin
            kind_q[0] <= cur_kind;
          end
        end
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      k_out           <= '0;
      e_out           <= '0;
      v_out           <= '0;
      beta_out        <= '0;
      ga_out          <= '0;
      gw_out          <= '0;
      k_out_enable    <= 1'b0;
      e_out_enable    <= 1'b0;
      v_out_enable    <= 1'b0;
      beta_out_enable <= 1'b0;
      ga_out_enable   <= 1'b0;
      gw_out_enable   <= 1'b0;
    end else begin
      k_out_enable    <= 1'b0;
      e_out_enable    <= 1'b0;
      v_out_enable    <= 1'b0;
      beta_out_enable <= 1'b0;
      ga_out_enable   <= 1'b0;
      gw_out_enable   <= 1'b0;
      if (row_done) begin
        // Head of queue names the finished row
        case (kind_q[0])
          KIND_K: begin
            k_out        <= row_result;
            k_out_enable <= 1'b1;
          end
          KIND_E: begin
            e_out        <= row_result;
            e_out_enable <= 1'b1;
          end
          KIND_V: begin
            v_out        <= row_result;
            v_out_enable <= 1'b1;
          end
          KIND_BETA: begin
            beta_out        <= row_result;
            beta_out_enable <= 1'b1;
          end
          KIND_GA: begin
            ga_out        <= row_result;
            ga_out_enable <= 1'b1;
          end
          default: begin
            gw_out        <= row_result;
            gw_out_enable <= 1'b1;
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_one_enable : assert property (
    @(posedge CLK) disable iff (RST)
    $onehot0({k_out_enable, e_out_enable, v_out_enable,
              beta_out_enable, ga_out_enable, gw_out_enable})
  );

  a_ready_pulse : assert property (
    @(posedge CLK) disable iff (RST)
    ready |=> !ready
  );

endmodule

// File: design/row_dot_product.sv
// Serial MAC for one weight row against h, one element per mac_enable
// Result is the Q8.8 sum shifted by FRAC_BITS and clamped to 16 bits
// A finished result holds while the next row starts accumulating
`timescale 1ns/1ns

module row_dot_product (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       mac_enable,
  input  logic                       row_first,
  input  logic                       row_last,
  input  dnc_write_types_pkg::data_t w_elem,
  input  dnc_write_types_pkg::data_t h_elem,
  output dnc_write_types_pkg::data_t row_result,
  output logic                       row_done
);

  import dnc_write_types_pkg::*;

  ////////////////////////////////////////////////////////////
  // Datapath signals
  ////////////////////////////////////////////////////////////

  // Full Q16.16 product
  logic signed [2*DATA_W-1:0] product;
  logic signed [ACC_W-1:0]    product_ext;
  logic signed [ACC_W-1:0]    acc;
  // One extra bit to see overflow of the running sum
  logic signed [ACC_W:0]      acc_sum;
  logic signed [ACC_W-1:0]    acc_next;
  logic signed [ACC_W-1:0]    scaled;
  data_t                      sat_result;

  assign product     = w_elem * h_elem;
  assign product_ext = ACC_W'(product);
  assign acc_sum     = {acc[ACC_W-1], acc} + {product_ext[ACC_W-1], product_ext};

  // Column 0 restarts from the product, old sum dropped
  assign acc_next = row_first ? product_ext : acc_sum[ACC_W-1:0];

  // Back to Q8.8, arithmetic shift keeps the sign
  assign scaled = acc_next >>> FRAC_BITS;

  // Clamp into the 16-bit range
  always_comb begin
    if (scaled > ACC_W'(DATA_MAX)) begin
      sat_result = DATA_MAX;
    end else if (scaled < ACC_W'(DATA_MIN)) begin
      sat_result = DATA_MIN;
    end else begin
      sat_result = scaled[DATA_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Accumulator and result registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (mac_enable) begin
      acc <= acc_next;
    end
    // Row end captures the sum including the last product
    if (mac_enable && row_last) begin
      row_result <= sat_result;
    end
  end

  // Done strobe, one cycle after the last element
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_done <= 1'b0;
    end else begin
      row_done <= mac_enable && row_last;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Row markers only come with an accepted weight
  a_markers_need_enable : assert property (
    @(posedge CLK) disable iff (RST)
    (row_first || row_last) |-> mac_enable
  );

  // Running sum stays inside the accumulator width
  a_acc_headroom : assert property (
    @(posedge CLK) disable iff (RST)
    (mac_enable && !row_first) |-> (acc_sum[ACC_W] == acc_sum[ACC_W-1])
  );

endmodule

// File: design/hidden_state_buffer.sv
// Holds the SIZE_L elements of h for the length of one job
// Read port is combinational; index must stay below SIZE_L
`timescale 1ns/1ns

module hidden_state_buffer (
  input  logic                                  CLK,
  input  logic                                  RST,
  input  logic                                  h_write,
  input  logic [dnc_write_types_pkg::IDX_W-1:0] h_index,
  input  dnc_write_types_pkg::data_t            h_in,
  output dnc_write_types_pkg::data_t            h_elem
);

  import dnc_write_types_pkg::*;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // One register per hidden-state element
  data_t h_mem [SIZE_L];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < SIZE_L; i++) begin
        h_mem[i] <= '0;
      end
    end else if (h_write) begin
      // Element at the current column
      h_mem[h_index] <= h_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  // Same index serves load and MAC phases
  assign h_elem = h_mem[h_index];

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Controller column counter must not run past L on a load
  a_write_index_in_range : assert property (
    @(posedge CLK) disable iff (RST)
    h_write |-> (int'(h_index) < SIZE_L)
  );

endmodule

// File: design/dnc_write_ctrl_pkg.sv
// Sequencing types of the write interface
// Weight order on the bus follows the phase order below
package dnc_write_ctrl_pkg;

  // Phases of the controller FSM
  typedef enum logic [3:0] {
    IDLE,
    LOAD_H,
    ROWS_K,
    ROWS_E,
    ROWS_V,
    ROW_BETA,
    ROW_GA,
    ROW_GW,
    FINISH
  } write_phase_e;

  // Output a finished row feeds
  typedef enum logic [2:0] {
    KIND_K,
    KIND_E,
    KIND_V,
    KIND_BETA,
    KIND_GA,
    KIND_GW
  } result_kind_e;

endpackage

// File: design/dnc_write_types_pkg.sv
// Widths and sizes are fixed here; nothing in the design is sized at runtime
// Signed Q8.8 arithmetic throughout, results saturate to 16 bits
package dnc_write_types_pkg;

  ////////////////////////////////////////////////////////////
  // Numeric format
  ////////////////////////////////////////////////////////////

  localparam int DATA_W    = 16;
  localparam int FRAC_BITS = 8;
  // Full-width product plus growth headroom
  localparam int ACC_W     = 40;

  // One Q8.8 word
  typedef logic signed [DATA_W-1:0] data_t;

  // Clamp bounds after scaling
  localparam data_t DATA_MAX = 16'sh7FFF;
  localparam data_t DATA_MIN = -16'sh8000;

  ////////////////////////////////////////////////////////////
  // Sizes of the write interface
  ////////////////////////////////////////////////////////////

  // Hidden-state length
  localparam int SIZE_L    = 4;
  // Memory word width, length of k, e and v
  localparam int SIZE_W    = 4;
  localparam int IDX_W     = (SIZE_L > 1) ? $clog2(SIZE_L) : 1;
  localparam int ROW_IDX_W = (SIZE_W > 1) ? $clog2(SIZE_W) : 1;

endpackage
